//--- build.f
verilog/mipsCtrlPkg.sv
verilog/instrDecoder.sv
verilog/stateSequencer.sv
verilog/ctrlWordDecoder.sv
verilog/mipsControl.sv
verification/ctrlChecker.sv
verification/tbMipsControl.sv

//--- run.sh
#!/bin/sh
# build the control unit testbench with Verilator, run it, then look for the pass line
verilator --binary --timing --top-module tbMipsControl -f build.f -o simMipsControl \
	&& ./obj_dir/simMipsControl | tee sim.log \
	&& grep -q "Testbench passed" sim.log \
	&& echo "run.sh: simulation ok" \
	|| { echo "run.sh: simulation did not pass"; exit 1; }

//--- verification/ctrlChecker.sv
`timescale 1ns/1ns

module ctrlChecker import mipsCtrlPkg::*;
();

	localparam int CW = $bits(ctrlWord_t);

	int stateErrs = 0;
	int ctrlErrs = 0;
	int pcLoadErrs = 0;
	logic armed = 1'b0;					// first edge may still see an unknown state
	logic [STATE_W-1:0] expState = RESET;
	logic [STATE_W-1:0] curState;
	logic [CW-1:0] gotWord;

	function automatic logic [STATE_W-1:0] nextStateFor(input logic [STATE_W-1:0] s,
		input logic [5:0] op, input logic [5:0] fn);
		case (s)
			RESET: return STACK_INIT;
			FETCH: return FETCH_MEM_DELAY1;
			FETCH_MEM_DELAY1: return FETCH_MEM_DELAY2;
			FETCH_MEM_DELAY2: return DECODE;
			DECODE:
			begin
				casez ({op, fn})			// opcode then funct, MIPS encodings
					12'b000000_100000: return ADD;
					12'b000000_100010: return SUB;
					12'b000000_100100: return AND;
					12'b000000_100110: return XOR;
					12'b000000_000000: return NOP;
					12'b000010_??????: return J;
					12'b000100_??????: return BEQ;
					12'b000101_??????: return BNE;
					12'b001111_??????: return LUI;
					12'b100011_??????: return LW_ADDRESS_COMP;
					12'b101011_??????: return SW_ADDRESS_COMP;
					default: return BREAK;		// break funct and anything unknown
				endcase
			end
			ADD, SUB, AND, XOR: return R_WAIT;
			BREAK: return BREAK;
			LW_ADDRESS_COMP: return LW;
			LW: return LW_DELAY1;
			LW_DELAY1: return LW_DELAY2;
			LW_DELAY2: return WRITE_BACK;
			SW_ADDRESS_COMP: return SW;
			default: return FETCH;			// stack init and last state of each instruction
		endcase
	endfunction

	// flags pcWrite pcWriteCond memWrite irWrite regWrite aLoad bLoad mdrLoad aluOutLoad clearRegs,
	// then aluSel memToReg pcSource aluSrcA aluSrcB iorD regDst
	function automatic logic [CW-1:0] ctrlWordFor(input logic [STATE_W-1:0] s);
		case (s)
			RESET: return {10'b0000000001, ALU_NONE, 3'd0, 3'd0, 1'b0, 2'd0, 2'd0, 2'd0};
			STACK_INIT: return {10'b0000000000, ALU_NONE, 3'd3, 3'd0, 1'b0, 2'd0, 2'd0, 2'd2};
			FETCH, FETCH_MEM_DELAY1:
				return {10'b0000000000, ALU_NONE, 3'd0, 3'd0, 1'b0, 2'd1, 2'd0, 2'd0};
			FETCH_MEM_DELAY2:
				return {10'b1001000100, ALU_ADD, 3'd0, 3'd0, 1'b0, 2'd1, 2'd0, 2'd0};
			DECODE: return {10'b0000011010, ALU_ADD, 3'd0, 3'd0, 1'b0, 2'd3, 2'd0, 2'd0};
			ADD: return {10'b0000000010, ALU_ADD, 3'd0, 3'd0, 1'b1, 2'd0, 2'd0, 2'd0};
			SUB: return {10'b0000000010, ALU_SUB, 3'd0, 3'd0, 1'b1, 2'd0, 2'd0, 2'd0};
			AND: return {10'b0000000010, ALU_AND, 3'd0, 3'd0, 1'b1, 2'd0, 2'd0, 2'd0};
			XOR: return {10'b0000000010, ALU_XOR, 3'd0, 3'd0, 1'b1, 2'd0, 2'd0, 2'd0};
			R_WAIT: return {10'b0000100000, ALU_NONE, 3'd0, 3'd0, 1'b0, 2'd0, 2'd0, 2'd1};
			BEQ, BNE: return {10'b0100000000, ALU_SUB, 3'd0, 3'd1, 1'b1, 2'd0, 2'd0, 2'd0};
			J: return {10'b1000000010, ALU_ADD, 3'd0, 3'd2, 1'b0, 2'd3, 2'd1, 2'd0};
			LUI: return {10'b0000100000, ALU_NONE, 3'd2, 3'd0, 1'b0, 2'd0, 2'd0, 2'd0};
			LW_ADDRESS_COMP, SW_ADDRESS_COMP:
				return {10'b0000000010, ALU_ADD, 3'd0, 3'd0, 1'b1, 2'd2, 2'd0, 2'd0};
			LW, LW_DELAY1, LW_DELAY2:
				return {10'b0000000100, ALU_NONE, 3'd0, 3'd0, 1'b0, 2'd0, 2'd1, 2'd0};
			SW: return {10'b0010000000, ALU_NONE, 3'd0, 3'd0, 1'b0, 2'd0, 2'd1, 2'd0};
			WRITE_BACK: return {10'b0000100000, ALU_NONE, 3'd1, 3'd0, 1'b0, 2'd0, 2'd0, 2'd0};
			default: return '0;				// NOP and BREAK drive nothing
		endcase
	endfunction

	function automatic logic pcLoadFor(input logic [STATE_W-1:0] s, input logic zero);
		case (s)
			FETCH_MEM_DELAY2, J: return 1'b1;	// plain pcWrite
			BEQ: return zero;
			BNE: return ~zero;
			default: return 1'b0;
		endcase
	endfunction

	assign curState = tbMipsControl.dut.stateOut;
	assign gotWord = {tbMipsControl.dut.pcWrite, tbMipsControl.dut.pcWriteCond,
		tbMipsControl.dut.memWrite, tbMipsControl.dut.irWrite, tbMipsControl.dut.regWrite,
		tbMipsControl.dut.aLoad, tbMipsControl.dut.bLoad, tbMipsControl.dut.mdrLoad,
		tbMipsControl.dut.aluOutLoad, tbMipsControl.dut.clearRegs, tbMipsControl.dut.aluSel,
		tbMipsControl.dut.memToReg, tbMipsControl.dut.pcSource, tbMipsControl.dut.aluSrcA,
		tbMipsControl.dut.aluSrcB, tbMipsControl.dut.iorD, tbMipsControl.dut.regDst};

	// values seen here are the ones held through the cycle that ends at this edge
	always @(posedge tbMipsControl.dut.Clk)
	begin
		if (tbMipsControl.dut.Reset_signal)
			expState = RESET;				// async reset overrides the prediction
		if (armed && curState !== expState)
		begin
			stateErrs++;
			$display("error at %0t ns: state %0d, expected %0d", $time, curState, expState);
		end
		if (armed && gotWord !== ctrlWordFor(curState))
		begin
			ctrlErrs++;
			$display("error at %0t ns: control word %h in state %0d, expected %h",
				$time, gotWord, curState, ctrlWordFor(curState));
		end
		if (armed && tbMipsControl.dut.pcLoad !== pcLoadFor(curState, tbMipsControl.dut.aluZero))
		begin
			pcLoadErrs++;
			$display("error at %0t ns: pcLoad %b in state %0d with aluZero %b",
				$time, tbMipsControl.dut.pcLoad, curState, tbMipsControl.dut.aluZero);
		end
		if (tbMipsControl.dut.Reset_signal)
			expState = RESET;				// reset still held at this edge
		else
			expState = nextStateFor(curState, tbMipsControl.dut.opCode,
				tbMipsControl.dut.funct);
		armed = 1'b1;
	end

endmodule

//--- verification/tbMipsControl.sv
`timescale 1ns/1ns

module tbMipsControl import mipsCtrlPkg::*;
();

	logic Clk = 1'b0;
	logic Reset_signal;
	logic [OP_W-1:0] opCode;
	logic [FUNCT_W-1:0] funct;
	logic aluZero;
	logic [STATE_W-1:0] stateOut;
	logic pcLoad, pcWrite, pcWriteCond, memWrite, irWrite, regWrite;
	logic aluSrcA, aLoad, bLoad, mdrLoad, aluOutLoad, clearRegs;
	logic [ALU_W-1:0] aluSel;
	logic [2:0] memToReg, pcSource;
	logic [1:0] aluSrcB, iorD, regDst;
	logic [15:0] lfsr;
	logic [7:0] pick;
	logic [OP_W-1:0] opTable [8];
	logic [FUNCT_W-1:0] functTable [8];
	int timeouts;

	mipsControl dut (.*);

	ctrlChecker ctrlCheck ();

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic drawBits(input int n, output logic [7:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr = lfsrStep(lfsr);
			v = {v[6:0], lfsr[0]};		// one step per bit
		end
	endtask

	task automatic driveRandom();
		drawBits(3, pick);
		opCode = opTable[pick[2:0]];
		drawBits(3, pick);
		funct = functTable[pick[2:0]];
		drawBits(1, pick);
		aluZero = pick[0];
	endtask

	task automatic waitForState(input logic [STATE_W-1:0] target, input int limit,
		input string what);
		int n;
		n = 0;
		while (stateOut !== target && n < limit)
		begin
			@(negedge Clk);
			n++;
		end
		if (stateOut !== target)
		begin
			timeouts++;
			$display("timeout: the control unit did not reach %s within %0d cycles", what, limit);
		end
	endtask

	// fresh reset with a bad pattern held on the inputs, then check the halt holds
	task automatic haltRun(input logic [OP_W-1:0] op, input logic [FUNCT_W-1:0] fn,
		input string what);
		@(negedge Clk);
		Reset_signal = 1'b1;
		opCode = op;
		funct = fn;
		repeat (3) @(negedge Clk);
		Reset_signal = 1'b0;
		waitForState(BREAK, 20, what);
		repeat (6)
		begin
			@(negedge Clk);
			driveRandom();				// halt must ignore new instructions
		end
	endtask

	initial
	begin
		forever #5 Clk = ~Clk;
	end

	initial
	begin
		Reset_signal = 1'b1;
		opCode = '0;
		funct = '0;
		aluZero = 1'b0;
		lfsr = 16'd27;
		timeouts = 0;
		opTable = '{6'h00, 6'h02, 6'h04, 6'h05, 6'h0f, 6'h23, 6'h2b, 6'h00};	// R-type twice
		functTable = '{6'h20, 6'h22, 6'h24, 6'h26, 6'h00, 6'h20, 6'h22, 6'h26};
		repeat (3) @(negedge Clk);
		Reset_signal = 1'b0;
		waitForState(FETCH, 5, "FETCH after reset");
		repeat (600)
		begin
			@(negedge Clk);
			driveRandom();
		end
		opCode = 6'h00;
		funct = 6'h0d;					// break funct
		aluZero = 1'b0;
		waitForState(BREAK, 20, "BREAK from the break funct");
		haltRun(6'h3f, 6'h00, "BREAK from an illegal opcode");
		haltRun(6'h00, 6'h3f, "BREAK from an illegal funct");
		@(negedge Clk);
		$display("state errors %0d, control errors %0d, pcLoad errors %0d, timeouts %0d",
			ctrlCheck.stateErrs, ctrlCheck.ctrlErrs, ctrlCheck.pcLoadErrs, timeouts);
		if (ctrlCheck.stateErrs + ctrlCheck.ctrlErrs + ctrlCheck.pcLoadErrs + timeouts == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- verilog/ctrlWordDecoder.sv
`timescale 1ns/1ns

module ctrlWordDecoder import mipsCtrlPkg::*;
(
	input ctrlState_t state,
	input logic aluZero,
	output ctrlWord_t ctrl,
	output logic pcLoad
);

	logic branchTaken;

	always_comb
	begin
		ctrl = '0;					// idle word, BREAK and NOP keep it
		case (state)
			RESET:
				ctrl.clearRegs = 1'b1;
			STACK_INIT:
			begin
				ctrl.memToReg = 3'd3;		// stack pointer init value
				ctrl.regDst = 2'd2;
			end
			FETCH, FETCH_MEM_DELAY1:
				ctrl.aluSrcB = 2'd1;		// keep pc + 4 on the alu
			FETCH_MEM_DELAY2:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.irWrite = 1'b1;
				ctrl.mdrLoad = 1'b1;
				ctrl.aluSel = ALU_ADD;
				ctrl.aluSrcB = 2'd1;
			end
			DECODE:
			begin
				ctrl.aLoad = 1'b1;
				ctrl.bLoad = 1'b1;
				ctrl.aluOutLoad = 1'b1;		// branch target, ready for BEQ/BNE
				ctrl.aluSel = ALU_ADD;
				ctrl.aluSrcB = 2'd3;		// offset shifted by 2
			end
			ADD, SUB, AND, XOR:
			begin
				ctrl.aluOutLoad = 1'b1;
				ctrl.aluSrcA = 1'b1;		// A op B
				case (state)
					ADD: ctrl.aluSel = ALU_ADD;
					SUB: ctrl.aluSel = ALU_SUB;
					AND: ctrl.aluSel = ALU_AND;
					default: ctrl.aluSel = ALU_XOR;
				endcase
			end
			R_WAIT:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 2'd1;			// rd
			end
			BEQ, BNE:
			begin
				ctrl.pcWriteCond = 1'b1;
				ctrl.aluSel = ALU_SUB;		// compare A and B
				ctrl.aluSrcA = 1'b1;
				ctrl.pcSource = 3'd1;		// target from aluOut
			end
			J:
			begin
				ctrl.pcWrite = 1'b1;
				ctrl.aluOutLoad = 1'b1;
				ctrl.aluSel = ALU_ADD;
				ctrl.pcSource = 3'd2;		// jump field concat
				ctrl.aluSrcB = 2'd3;
				ctrl.iorD = 2'd1;
			end
			LUI:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 3'd2;		// upper immediate into rt
			end
			LW_ADDRESS_COMP, SW_ADDRESS_COMP:
			begin
				ctrl.aluOutLoad = 1'b1;
				ctrl.aluSel = ALU_ADD;		// A + sign extended offset
				ctrl.aluSrcA = 1'b1;
				ctrl.aluSrcB = 2'd2;
			end
			LW, LW_DELAY1, LW_DELAY2:
			begin
				ctrl.mdrLoad = 1'b1;
				ctrl.iorD = 2'd1;			// data address
			end
			SW:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.iorD = 2'd1;
			end
			WRITE_BACK:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 3'd1;		// mdr into rt
			end
			default:
				ctrl = '0;
		endcase
	end

	// BNE branches on a nonzero difference, BEQ on zero
	assign branchTaken = (state == BNE) ? ~aluZero : aluZero;
	assign pcLoad = ctrl.pcWrite | (ctrl.pcWriteCond & branchTaken);

endmodule

//--- verilog/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder import mipsCtrlPkg::*;
(
	input logic [OP_W-1:0] opCode,
	input logic [FUNCT_W-1:0] funct,
	output instrClass_t instrClass
);

	always_comb
	begin
		instrClass = badI;			// anything not listed below
		case (opCode)
			FUNCT_OP:
			begin
				case (funct)
					ADD_FUNCT: instrClass = addI;
					SUB_FUNCT: instrClass = subI;
					AND_FUNCT: instrClass = andI;
					XOR_FUNCT: instrClass = xorI;
					NOP_FUNCT: instrClass = nopI;
					BREAK_FUNCT: instrClass = breakI;
					default: instrClass = badI;
				endcase
			end
			BEQ_OP: instrClass = beqI;
			BNE_OP: instrClass = bneI;
			LW_OP: instrClass = lwI;
			SW_OP: instrClass = swI;
			LUI_OP: instrClass = luiI;
			J_OP: instrClass = jI;
			default: instrClass = badI;
		endcase
	end

endmodule

//--- verilog/mipsControl.sv
`timescale 1ns/1ns

module mipsControl import mipsCtrlPkg::*;
(
	input logic Clk,
	input logic Reset_signal,
	input logic [OP_W-1:0] opCode,
	input logic [FUNCT_W-1:0] funct,
	input logic aluZero,			// from the datapath alu
	output logic [STATE_W-1:0] stateOut,
	output logic pcLoad,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic memWrite,
	output logic irWrite,
	output logic regWrite,
	output logic [ALU_W-1:0] aluSel,
	output logic [2:0] memToReg,
	output logic [2:0] pcSource,
	output logic aluSrcA,
	output logic [1:0] aluSrcB,
	output logic [1:0] iorD,
	output logic [1:0] regDst,
	output logic aLoad,
	output logic bLoad,
	output logic mdrLoad,
	output logic aluOutLoad,
	output logic clearRegs
);

	instrClass_t instrClass;
	ctrlState_t state;
	ctrlWord_t ctrl;

	instrDecoder uInstrDecoder
	(
		.opCode(opCode),
		.funct(funct),
		.instrClass(instrClass)
	);

	stateSequencer uStateSequencer
	(
		.Clk(Clk),
		.Reset_signal(Reset_signal),
		.instrClass(instrClass),
		.state(state)
	);

	ctrlWordDecoder uCtrlWordDecoder
	(
		.state(state),
		.aluZero(aluZero),
		.ctrl(ctrl),
		.pcLoad(pcLoad)
	);

	assign stateOut = state;		// debug view of the FSM
	assign pcWrite = ctrl.pcWrite;
	assign pcWriteCond = ctrl.pcWriteCond;
	assign memWrite = ctrl.memWrite;
	assign irWrite = ctrl.irWrite;
	assign regWrite = ctrl.regWrite;
	assign aluSel = ctrl.aluSel;
	assign memToReg = ctrl.memToReg;
	assign pcSource = ctrl.pcSource;
	assign aluSrcA = ctrl.aluSrcA;
	assign aluSrcB = ctrl.aluSrcB;
	assign iorD = ctrl.iorD;
	assign regDst = ctrl.regDst;
	assign aLoad = ctrl.aLoad;
	assign bLoad = ctrl.bLoad;
	assign mdrLoad = ctrl.mdrLoad;
	assign aluOutLoad = ctrl.aluOutLoad;
	assign clearRegs = ctrl.clearRegs;

endmodule

//--- verilog/mipsCtrlPkg.sv
package mipsCtrlPkg;

	localparam int OP_W = 6;		// opcode field
	localparam int FUNCT_W = 6;		// funct field, only for FUNCT_OP
	localparam int STATE_W = 5;
	localparam int CLASS_W = 4;
	localparam int ALU_W = 3;

	typedef enum logic [OP_W-1:0]
	{
		FUNCT_OP = 6'h00,
		J_OP = 6'h02,
		BEQ_OP = 6'h04,
		BNE_OP = 6'h05,
		LUI_OP = 6'h0f,
		LW_OP = 6'h23,
		SW_OP = 6'h2b
	} opCode_t;

	typedef enum logic [FUNCT_W-1:0]
	{
		NOP_FUNCT = 6'h00,
		BREAK_FUNCT = 6'h0d,
		ADD_FUNCT = 6'h20,
		SUB_FUNCT = 6'h22,
		AND_FUNCT = 6'h24,
		XOR_FUNCT = 6'h26
	} funct_t;

	// what decode can tell apart, badI covers every unknown pattern
	typedef enum logic [CLASS_W-1:0]
	{
		addI, subI, andI, xorI, nopI, breakI,
		beqI, bneI, lwI, swI, luiI, jI, badI
	} instrClass_t;

	typedef enum logic [STATE_W-1:0]
	{
		RESET, STACK_INIT,
		FETCH, FETCH_MEM_DELAY1, FETCH_MEM_DELAY2, DECODE,
		ADD, SUB, AND, XOR, R_WAIT,
		NOP, BREAK,
		BEQ, BNE, J, LUI,
		LW_ADDRESS_COMP, LW, LW_DELAY1, LW_DELAY2, WRITE_BACK,
		SW_ADDRESS_COMP, SW
	} ctrlState_t;

	typedef enum logic [ALU_W-1:0]
	{
		ALU_NONE = 3'd0,
		ALU_ADD = 3'd1,
		ALU_SUB = 3'd2,
		ALU_AND = 3'd3,
		ALU_XOR = 3'd6
	} aluSel_t;

	typedef struct packed
	{
		logic pcWrite;
		logic pcWriteCond;		// branch, qualified by alu zero
		logic memWrite;
		logic irWrite;
		logic regWrite;
		logic aLoad;
		logic bLoad;
		logic mdrLoad;
		logic aluOutLoad;
		logic clearRegs;		// one clear for all datapath regs
		aluSel_t aluSel;
		logic [2:0] memToReg;
		logic [2:0] pcSource;
		logic aluSrcA;			// 0 pc, 1 reg A
		logic [1:0] aluSrcB;
		logic [1:0] iorD;		// 0 instruction, 1 data
		logic [1:0] regDst;
	} ctrlWord_t;

endpackage

//--- verilog/stateSequencer.sv
`timescale 1ns/1ns

module stateSequencer import mipsCtrlPkg::*;
(
	input logic Clk,
	input logic Reset_signal,
	input instrClass_t instrClass,
	output ctrlState_t state
);

	ctrlState_t nextState;

	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
			state <= RESET;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = RESET;			// undefined encodings restart the machine
		case (state)
			RESET: nextState = STACK_INIT;
			STACK_INIT: nextState = FETCH;
			FETCH: nextState = FETCH_MEM_DELAY1;
			FETCH_MEM_DELAY1: nextState = FETCH_MEM_DELAY2;
			FETCH_MEM_DELAY2: nextState = DECODE;
			DECODE:
			begin
				case (instrClass)
					addI: nextState = ADD;
					subI: nextState = SUB;
					andI: nextState = AND;
					xorI: nextState = XOR;
					nopI: nextState = NOP;
					beqI: nextState = BEQ;
					bneI: nextState = BNE;
					jI: nextState = J;
					luiI: nextState = LUI;
					lwI: nextState = LW_ADDRESS_COMP;
					swI: nextState = SW_ADDRESS_COMP;
					default: nextState = BREAK;		// breakI and badI halt
				endcase
			end
			ADD, SUB, AND, XOR: nextState = R_WAIT;
			R_WAIT: nextState = FETCH;
			NOP: nextState = FETCH;
			BREAK: nextState = BREAK;		// halt until reset
			BEQ, BNE: nextState = FETCH;
			J: nextState = FETCH;
			LUI: nextState = FETCH;
			LW_ADDRESS_COMP: nextState = LW;
			LW: nextState = LW_DELAY1;
			LW_DELAY1: nextState = LW_DELAY2;
			LW_DELAY2: nextState = WRITE_BACK;
			WRITE_BACK: nextState = FETCH;
			SW_ADDRESS_COMP: nextState = SW;
			SW: nextState = FETCH;
			default: nextState = RESET;
		endcase
	end

endmodule
